// File: descFifoBank.sv
// --------------------------------------
// Per-flow descriptor queues
// Circular buffers with fall-through read ports and free counts
// --------------------------------------

`timescale 1ns/1ps

module descFifoBank (
  input  logic                          CLK,
  input  logic                          reset,
  input  descMgrPkg::decodedWrite_t     dec,
  input  logic [descMgrPkg::FLOWS-1:0]  rdEn,
  output descMgrPkg::descWord_t         rdData [descMgrPkg::FLOWS],
  output logic [descMgrPkg::FLOWS-1:0]  empty,
  output logic [descMgrPkg::CNT_W-1:0]  freeSlots [descMgrPkg::FLOWS]
);

  // --------------------------------------
  // Storage and pointers
  // --------------------------------------

  descMgrPkg::descWord_t mem [descMgrPkg::FLOWS][descMgrPkg::QUEUE_DEPTH];

  // Depth is a power of two, pointers wrap on their own
  logic [descMgrPkg::PTR_W-1:0] rdPtr [descMgrPkg::FLOWS];
  logic [descMgrPkg::PTR_W-1:0] wrPtr [descMgrPkg::FLOWS];
  logic [descMgrPkg::CNT_W-1:0] count [descMgrPkg::FLOWS];

  // Qualified push and pop per flow
  logic [descMgrPkg::FLOWS-1:0] doPush;
  logic [descMgrPkg::FLOWS-1:0] doPop;

  // --------------------------------------
  // Strobe qualification
  // --------------------------------------

  always_comb begin
    for (int f = 0; f < descMgrPkg::FLOWS; f++) begin
      // Scheduler keeps room for a block, full check is a backstop
      doPush[f] = dec.push
                  && (dec.flow == descMgrPkg::FLOW_W'(f))
                  && (count[f] != descMgrPkg::CNT_W'(descMgrPkg::QUEUE_DEPTH));
      // Pop on empty queue is dropped
      doPop[f] = rdEn[f] && (count[f] != '0);
    end
  end

  // --------------------------------------
  // Queue memory
  // --------------------------------------

  always_ff @(posedge CLK) begin
    for (int f = 0; f < descMgrPkg::FLOWS; f++) begin
      if (doPush[f]) begin
        mem[f][wrPtr[f]] <= dec.desc;
      end
    end
  end

  // --------------------------------------
  // Pointers and fill counts
  // --------------------------------------

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int f = 0; f < descMgrPkg::FLOWS; f++) begin
        rdPtr[f] <= '0;
        wrPtr[f] <= '0;
        count[f] <= '0;
      end
    end else begin
      for (int f = 0; f < descMgrPkg::FLOWS; f++) begin
        if (doPush[f]) begin
          wrPtr[f] <= wrPtr[f] + 1'b1;
        end
        if (doPop[f]) begin
          rdPtr[f] <= rdPtr[f] + 1'b1;
        end
        // Simultaneous push and pop leaves count as is
        case ({doPush[f], doPop[f]})
          2'b10:   count[f] <= count[f] + 1'b1;
          2'b01:   count[f] <= count[f] - 1'b1;
          default: count[f] <= count[f];
        endcase
      end
    end
  end

  // --------------------------------------
  // Read side
  // --------------------------------------

  always_comb begin
    for (int f = 0; f < descMgrPkg::FLOWS; f++) begin
      empty[f] = (count[f] == '0);
      // Head entry shown without waiting for a pop
      rdData[f] = mem[f][rdPtr[f]];
      // Free room seen by the fetch scheduler
      freeSlots[f] = descMgrPkg::CNT_W'(descMgrPkg::QUEUE_DEPTH) - count[f];
    end
  end

endmodule

// File: descManager.f
descMgrPkg.sv
descWriteDecode.sv
descFifoBank.sv
descManagerCtrl.sv
descManager.sv
descManager_sva.sv
descManagerTb.sv

// File: descManager.sv
// --------------------------------------
// Multi-flow descriptor manager
// Fetches descriptor blocks and queues them per flow
// --------------------------------------

`timescale 1ns/1ps

module descManager (
  input  logic                          CLK,
  input  logic                          reset,
  input  descMgrPkg::flowInit_t         init,
  input  descMgrPkg::winWrite_t         winWr,
  input  logic [descMgrPkg::FLOWS-1:0]  rdEn,
  output descMgrPkg::dmaReq_t           dmaReq,
  output descMgrPkg::descWord_t         rdData [descMgrPkg::FLOWS],
  output logic [descMgrPkg::FLOWS-1:0]  empty
);

  // --------------------------------------
  // Internal links
  // --------------------------------------

  // Decoded window write, shared by control and queues
  descMgrPkg::decodedWrite_t    dec;
  // Queue room fed back to the scheduler
  logic [descMgrPkg::CNT_W-1:0] freeSlots [descMgrPkg::FLOWS];

  // Host writes into the window
  descWriteDecode decodeU (
    .winWr (winWr),
    .dec   (dec)
  );

  // Block pointers and fetch scheduling
  descManagerCtrl ctrlU (
    .CLK       (CLK),
    .reset     (reset),
    .init      (init),
    .dec       (dec),
    .freeSlots (freeSlots),
    .dmaReq    (dmaReq)
  );

  // Data descriptor storage
  descFifoBank fifoU (
    .CLK       (CLK),
    .reset     (reset),
    .dec       (dec),
    .rdEn      (rdEn),
    .rdData    (rdData),
    .empty     (empty),
    .freeSlots (freeSlots)
  );

endmodule

// File: descManagerCtrl.sv
// --------------------------------------
// Descriptor fetch controller
// Tracks block pointers per flow and schedules fetches round-robin
// --------------------------------------

`timescale 1ns/1ps

module descManagerCtrl (
  input  logic                          CLK,
  input  logic                          reset,
  input  descMgrPkg::flowInit_t         init,
  input  descMgrPkg::decodedWrite_t     dec,
  input  logic [descMgrPkg::CNT_W-1:0]  freeSlots [descMgrPkg::FLOWS],
  output descMgrPkg::dmaReq_t           dmaReq
);

  // Sequential block stride in bytes
  localparam logic [63:0] BLOCK_BYTES = 64'(descMgrPkg::BLOCK_SIZE * 8);

  // --------------------------------------
  // Per-flow state
  // --------------------------------------

  logic [descMgrPkg::FLOWS-1:0] started;
  logic [descMgrPkg::FLOWS-1:0] pending;
  // Link seen earlier in the current block
  logic [descMgrPkg::FLOWS-1:0] linkSeen;
  logic [63:0] blkAddr  [descMgrPkg::FLOWS];
  logic [63:0] linkAddr [descMgrPkg::FLOWS];

  // Scheduler
  logic [descMgrPkg::FLOWS-1:0]  eligible;
  logic [descMgrPkg::FLOW_W-1:0] lastGrant;
  logic [descMgrPkg::FLOW_W-1:0] cand;
  logic [descMgrPkg::FLOW_W-1:0] grantFlow;
  logic                          grantValid;

  // Pointer update for the written flow
  logic [63:0] linkTarget;
  logic [63:0] nextAddr;

  // Registered request
  logic                          reqValid;
  logic [descMgrPkg::FLOW_W-1:0] reqFlow;
  logic [63:0]                   reqAddr;

  // --------------------------------------
  // Eligibility and arbitration
  // --------------------------------------

  always_comb begin
    for (int f = 0; f < descMgrPkg::FLOWS; f++) begin
      // Needs room for a whole block before asking
      eligible[f] = started[f] && !pending[f]
                    && (freeSlots[f] >= descMgrPkg::CNT_W'(descMgrPkg::BLOCK_SIZE));
    end
  end

  // Search starts just after the last winner
  // FLOWS is a power of two, so the candidate wraps by itself
  always_comb begin
    grantValid = 1'b0;
    grantFlow  = lastGrant;
    cand       = lastGrant;
    for (int i = 1; i <= descMgrPkg::FLOWS; i++) begin
      cand = lastGrant + descMgrPkg::FLOW_W'(i);
      if (!grantValid && eligible[cand]) begin
        grantValid = 1'b1;
        grantFlow  = cand;
      end
    end
  end

  // --------------------------------------
  // Next block address
  // --------------------------------------

  always_comb begin
    linkTarget = {dec.desc.link.nextBlk, 3'b000};
    // Link in the last slot wins, then one seen earlier
    if (dec.link) begin
      nextAddr = linkTarget;
    end else if (linkSeen[dec.flow]) begin
      nextAddr = linkAddr[dec.flow];
    end else begin
      nextAddr = blkAddr[dec.flow] + BLOCK_BYTES;
    end
  end

  // --------------------------------------
  // Control state
  // --------------------------------------

  always_ff @(posedge CLK) begin
    if (reset) begin
      started   <= '0;
      pending   <= '0;
      linkSeen  <= '0;
      lastGrant <= '0;
      reqValid  <= 1'b0;
    end else begin
      reqValid <= grantValid;
      if (grantValid) begin
        pending[grantFlow] <= 1'b1;
        lastGrant          <= grantFlow;
      end
      // Last word of the block ends the fetch
      if (dec.last) begin
        pending[dec.flow]  <= 1'b0;
        linkSeen[dec.flow] <= 1'b0;
      end else if (dec.link) begin
        linkSeen[dec.flow] <= 1'b1;
      end
      // Start command restarts the flow from scratch
      if (init.valid) begin
        started[init.flow]  <= 1'b1;
        pending[init.flow]  <= 1'b0;
        linkSeen[init.flow] <= 1'b0;
      end
    end
  end

  // --------------------------------------
  // Addresses and request payload
  // --------------------------------------

  always_ff @(posedge CLK) begin
    if (grantValid) begin
      reqFlow <= grantFlow;
      reqAddr <= blkAddr[grantFlow];
    end
    if (dec.link && !dec.last) begin
      linkAddr[dec.flow] <= linkTarget;
    end
    if (dec.last) begin
      blkAddr[dec.flow] <= nextAddr;
    end
    if (init.valid) begin
      blkAddr[init.flow] <= init.addr;
    end
  end

  assign dmaReq = '{valid: reqValid, flow: reqFlow, addr: reqAddr};

endmodule

// File: descManagerTb.sv
// --------------------------------------
// Descriptor manager testbench
// Host memory model, DMA responder and per-flow queue checker
// --------------------------------------

`timescale 1ns/1ps

module descManagerTb;

  localparam logic [63:0] BLOCK_BYTES = 64'(descMgrPkg::BLOCK_SIZE * 8);
  localparam int FINAL_COUNT = 48;
  // 200 cycles per expected descriptor plus idle and stall phases
  localparam int TIMEOUT = 200 * descMgrPkg::FLOWS * FINAL_COUNT + 1000;

  logic CLK;
  logic reset;
  descMgrPkg::flowInit_t init;
  descMgrPkg::winWrite_t winWr;
  logic [descMgrPkg::FLOWS-1:0] rdEn;
  descMgrPkg::dmaReq_t dmaReq;
  descMgrPkg::descWord_t rdData [descMgrPkg::FLOWS];
  logic [descMgrPkg::FLOWS-1:0] empty;

  // Per-flow bookkeeping
  logic [63:0] startAddr [descMgrPkg::FLOWS];
  logic [63:0] fetchAddr [descMgrPkg::FLOWS];
  int target [descMgrPkg::FLOWS];
  int popped [descMgrPkg::FLOWS];
  int reqCnt [descMgrPkg::FLOWS];
  int winReqs [descMgrPkg::FLOWS];
  int winPops [descMgrPkg::FLOWS];
  int wordIdx [descMgrPkg::FLOWS];
  int due [descMgrPkg::FLOWS];
  bit busy [descMgrPkg::FLOWS];
  bit stall;
  bit strayOn;
  int errors;
  int checks;
  int cycles;
  int linkWrites;

  descManager uut (
    .CLK    (CLK),
    .reset  (reset),
    .init   (init),
    .winWr  (winWr),
    .rdEn   (rdEn),
    .dmaReq (dmaReq),
    .rdData (rdData),
    .empty  (empty)
  );

  // --------------------------------------
  // Host memory model
  // --------------------------------------

  function automatic logic [63:0] hashAddr(input logic [63:0] a);
    logic [63:0] x;
    x = a * 64'h9e37_79b9_7f4a_7c15;
    x = x ^ (x >> 29);
    x = x * 64'hbf58_476d_1ce4_e5b9;
    return x ^ (x >> 32);
  endfunction

  // Every third block along the address line ends in a link
  function automatic bit isLinkBlock(input logic [63:0] blk);
    return ((blk / BLOCK_BYTES) % 3) == 2;
  endfunction

  // Block-aligned target in a 16 MB region
  function automatic logic [63:0] linkTargetOf(input logic [63:0] blk);
    return 64'h1_0000_0000 | (hashAddr(blk) & 64'h00ff_ffe0);
  endfunction

  function automatic logic [63:0] hostWord(input logic [63:0] addr);
    logic [63:0] blk;
    logic [63:0] tgt;
    logic [63:0] h;
    blk = addr & ~(BLOCK_BYTES - 64'd1);
    if (isLinkBlock(blk) && ((addr - blk) >> 3) == 64'(descMgrPkg::BLOCK_SIZE - 1)) begin
      tgt = linkTargetOf(blk);
      return {tgt[63:3], 2'b00, descMgrPkg::KIND_LINK};
    end
    h = hashAddr(addr);
    return {h[63:1], descMgrPkg::KIND_DATA};
  endfunction

  // n-th data descriptor of a flow, links followed and skipped
  function automatic logic [63:0] expectedDesc(input logic [63:0] start, input int n);
    logic [63:0] blk;
    logic [63:0] w;
    int seen;
    blk = start;
    seen = 0;
    while (seen <= n) begin
      for (int i = 0; i < descMgrPkg::BLOCK_SIZE; i++) begin
        w = hostWord(blk + 64'(i * 8));
        if (w[0] == descMgrPkg::KIND_DATA) begin
          if (seen == n) begin
            return w;
          end
          seen++;
        end
      end
      blk = isLinkBlock(blk) ? linkTargetOf(blk) : blk + BLOCK_BYTES;
    end
    return '0;
  endfunction

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic startFlow(input int f);
    @(posedge CLK);
    #1;
    init.valid = 1'b1;
    init.flow = descMgrPkg::FLOW_W'(f);
    init.addr = startAddr[f];
    @(posedge CLK);
    #1;
    init = '0;
  endtask

  task automatic waitTargets();
    for (int f = 0; f < descMgrPkg::FLOWS; f++) begin
      while (popped[f] < target[f]) begin
        @(posedge CLK);
      end
    end
  endtask

  // --------------------------------------
  // Clock and watchdog
  // --------------------------------------

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout after %0d cycles with descriptors still outstanding", cycles);
    $display("Checks: %0d  errors: %0d", checks, errors);
    $display("RESULT: FAIL");
    $finish;
  end

  // --------------------------------------
  // DMA responder, one block in flight per flow
  // --------------------------------------

  initial begin : responder
    int f;
    int pick;
    bit found;
    forever begin
      @(posedge CLK);
      #1;
      winWr = '0;
      if (dmaReq.valid === 1'b1) begin
        f = int'(dmaReq.flow);
        if (busy[f]) begin
          errors++;
          $display("Flow %0d requested a block while one was still in flight", f);
        end
        busy[f] = 1'b1;
        fetchAddr[f] = dmaReq.addr;
        wordIdx[f] = 0;
        due[f] = cycles + int'($urandom_range(10, 2));
        reqCnt[f]++;
        winReqs[f]++;
      end
      // Random start flow interleaves the blocks
      found = 1'b0;
      pick = int'($urandom_range(descMgrPkg::FLOWS - 1));
      for (int k = 0; k < descMgrPkg::FLOWS; k++) begin
        f = (pick + k) % descMgrPkg::FLOWS;
        if (!found && busy[f] && cycles >= due[f]) begin
          found = 1'b1;
          winWr.valid = 1'b1;
          winWr.addr = descMgrPkg::BASE_ADDR
                       + 32'((f * descMgrPkg::BLOCK_SIZE + wordIdx[f]) * 8);
          winWr.word = hostWord(fetchAddr[f] + 64'(wordIdx[f] * 8));
          if (winWr.word.link.kind == descMgrPkg::KIND_LINK) begin
            linkWrites++;
          end
          wordIdx[f]++;
          busy[f] = (wordIdx[f] != descMgrPkg::BLOCK_SIZE);
        end
      end
      // Stray writes just outside the window or misaligned
      if (!found && strayOn && $urandom_range(7) == 0) begin
        case ($urandom_range(2))
          0:       winWr.addr = descMgrPkg::BASE_ADDR - 32'd8;
          1:       winWr.addr = descMgrPkg::BASE_ADDR + descMgrPkg::WIN_BYTES;
          default: winWr.addr = descMgrPkg::BASE_ADDR + 32'd4;
        endcase
        winWr.valid = 1'b1;
        winWr.word = hashAddr({32'h0, winWr.addr}) & ~64'h1;
      end
    end
  end

  // --------------------------------------
  // Consumer and compare
  // --------------------------------------

  initial begin : consumer
    forever begin
      @(posedge CLK);
      #1;
      for (int f = 0; f < descMgrPkg::FLOWS; f++) begin
        rdEn[f] = 1'b0;
        if (!stall && empty[f] === 1'b0 && popped[f] < target[f]
            && $urandom_range(3) != 0) begin
          check($sformatf("flow%0d desc%0d", f, popped[f]),
                expectedDesc(startAddr[f], popped[f]), rdData[f]);
          popped[f]++;
          winPops[f]++;
          rdEn[f] = 1'b1;
        end
      end
    end
  end

  // --------------------------------------
  // Test sequence
  // --------------------------------------

  initial begin : mainSeq
    void'($urandom(32'hdeb7_3f8d));
    reset = 1'b1;
    init = '0;
    winWr = '0;
    rdEn = '0;
    stall = 1'b0;
    strayOn = 1'b0;
    errors = 0;
    checks = 0;
    linkWrites = 0;
    for (int f = 0; f < descMgrPkg::FLOWS; f++) begin
      startAddr[f] = 64'h2000_0000 + 64'(f) * 64'h40_0000;
      target[f] = 0;
      popped[f] = 0;
      reqCnt[f] = 0;
      winReqs[f] = 0;
      winPops[f] = 0;
      busy[f] = 1'b0;
      wordIdx[f] = 0;
      due[f] = 0;
    end
    repeat (4) @(posedge CLK);
    #1;
    reset = 1'b0;

    // Idle with stray writes, queues stay empty and no fetch
    strayOn = 1'b1;
    repeat (20) begin
      @(posedge CLK);
      #1;
      check("idleEmpty", 64'hf, 64'(empty));
    end
    check("idleRequests", 64'd0, 64'(reqCnt[0] + reqCnt[1] + reqCnt[2] + reqCnt[3]));

    // Single flow across sequential and linked blocks
    target[0] = 16;
    startFlow(0);
    waitTargets();

    // All flows interleaved
    for (int f = 1; f < descMgrPkg::FLOWS; f++) begin
      startFlow(f);
    end
    for (int f = 0; f < descMgrPkg::FLOWS; f++) begin
      target[f] = 32;
    end
    waitTargets();

    // Consumer stalls, fetching must stop at the queue limit
    stall = 1'b1;
    for (int f = 0; f < descMgrPkg::FLOWS; f++) begin
      winReqs[f] = 0;
      winPops[f] = 0;
    end
    repeat (80) @(posedge CLK);
    #1;
    for (int f = 0; f < descMgrPkg::FLOWS; f++) begin
      if (winReqs[f] > winPops[f] / descMgrPkg::BLOCK_SIZE + 2) begin
        errors++;
        $display("Flow %0d issued %0d requests while its consumer was stalled", f, winReqs[f]);
      end
      target[f] = FINAL_COUNT;
    end
    stall = 1'b0;
    waitTargets();
    check("linkWordsSeen", 64'd1, 64'(linkWrites > 0));

    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: descManager_sva.sv
// --------------------------------------
// Descriptor manager assertions
// Fetch and queue rules, bound to the top level
// --------------------------------------

`timescale 1ns/1ps

module descManagerSva (
  input logic                         CLK,
  input logic                         reset,
  input descMgrPkg::flowInit_t        init,
  input descMgrPkg::decodedWrite_t    dec,
  input descMgrPkg::dmaReq_t          dmaReq,
  input logic [descMgrPkg::FLOWS-1:0] rdEn,
  input logic [descMgrPkg::FLOWS-1:0] empty
);

  // Fetch outstanding as seen on the ports, request to last write
  logic [descMgrPkg::FLOWS-1:0] fetchOpen;
  // Start commands seen so far
  logic [descMgrPkg::FLOWS-1:0] startSeen;

  always_ff @(posedge CLK) begin
    if (reset) begin
      fetchOpen <= '0;
      startSeen <= '0;
    end else begin
      if (dmaReq.valid) begin
        fetchOpen[dmaReq.flow] <= 1'b1;
      end
      // Last word of the block closes it
      if (dec.last) begin
        fetchOpen[dec.flow] <= 1'b0;
      end
      // Restart drops any open fetch
      if (init.valid) begin
        startSeen[init.flow] <= 1'b1;
        fetchOpen[init.flow] <= 1'b0;
      end
    end
  end

  reqNotPending: assert property (@(posedge CLK) disable iff (reset)
    dmaReq.valid |-> !fetchOpen[dmaReq.flow])
    else $error("dmaReq for flow %0d while its fetch is pending", dmaReq.flow);

  reqOnlyStarted: assert property (@(posedge CLK) disable iff (reset)
    dmaReq.valid |-> startSeen[dmaReq.flow])
    else $error("dmaReq for flow %0d that was never started", dmaReq.flow);

  emptyAfterReset: assert property (@(posedge CLK)
    $fell(reset) |-> (empty == '1))
    else $error("empty not all high after reset");

  noPopOnEmpty: assert property (@(posedge CLK) disable iff (reset)
    (rdEn & empty) == '0)
    else $error("rdEn on empty flow, rdEn=%b empty=%b", rdEn, empty);

endmodule

bind descManager descManagerSva svaU (
  .CLK    (CLK),
  .reset  (reset),
  .init   (init),
  .dec    (dec),
  .dmaReq (dmaReq),
  .rdEn   (rdEn),
  .empty  (empty)
);

// File: descMgrPkg.sv
// --------------------------------------
// Descriptor manager shared definitions
// Sizes, window location and the descriptor formats
// --------------------------------------

package descMgrPkg;

  // --------------------------------------
  // Sizing
  // --------------------------------------

  // Number of independent flows
  localparam int FLOWS = 4;
  localparam int FLOW_W = 2;

  // Descriptors per host block
  localparam int BLOCK_SIZE = 4;
  localparam int IDX_W = 2;

  // Room for two whole blocks per flow
  localparam int QUEUE_DEPTH = 2 * BLOCK_SIZE;
  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  // Count must also hold QUEUE_DEPTH itself
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  // --------------------------------------
  // Write window
  // --------------------------------------

  localparam logic [31:0] BASE_ADDR = 32'h0004_0000;
  // One 8-byte word per descriptor slot
  localparam int WIN_WORDS = FLOWS * BLOCK_SIZE;
  localparam logic [31:0] WIN_BYTES = 32'(WIN_WORDS * 8);

  // Kind bit encoding, bit 0 of every descriptor
  localparam logic KIND_DATA = 1'b0;
  localparam logic KIND_LINK = 1'b1;

  // --------------------------------------
  // Descriptor formats
  // --------------------------------------

  typedef struct packed {
    logic [62:0] bufAddr;
    logic        kind;
  } descData_t;

  // Next block is 8-byte aligned, low three bits implied
  typedef struct packed {
    logic [60:0] nextBlk;
    logic [1:0]  rsvd;
    logic        kind;
  } descLink_t;

  // Same 64-bit word seen as data or as link
  typedef union packed {
    descData_t data;
    descLink_t link;
  } descWord_t;

  // --------------------------------------
  // Transfers between blocks
  // --------------------------------------

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    descWord_t   word;
  } winWrite_t;

  typedef struct packed {
    logic              valid;
    logic [FLOW_W-1:0] flow;
    logic [63:0]       addr;
  } dmaReq_t;

  // Strobes are already qualified by the window check
  typedef struct packed {
    logic              push;
    logic              link;
    logic [FLOW_W-1:0] flow;
    logic [IDX_W-1:0]  idx;
    logic              last;
    descWord_t         desc;
  } decodedWrite_t;

  typedef struct packed {
    logic              valid;
    logic [FLOW_W-1:0] flow;
    logic [63:0]       addr;
  } flowInit_t;

endpackage

// File: descWriteDecode.sv
// --------------------------------------
// Window write decoder
// Splits host writes into flow, block index and descriptor kind
// --------------------------------------

`timescale 1ns/1ps

module descWriteDecode (
  input  descMgrPkg::winWrite_t     winWr,
  output descMgrPkg::decodedWrite_t dec
);

  // Flow and index bits packed above the 8-byte word offset
  localparam int SLOT_W = descMgrPkg::IDX_W + descMgrPkg::FLOW_W;

  // Offset from window start, wraps for addresses below it
  logic [31:0] byteOff;
  // Word slot inside the window
  logic [SLOT_W-1:0] slot;
  logic inWin;

  // --------------------------------------
  // Address check
  // --------------------------------------

  always_comb begin
    byteOff = winWr.addr - descMgrPkg::BASE_ADDR;
    // Below-base addresses wrap to a huge offset and fail here too
    inWin = winWr.valid
            && (byteOff < descMgrPkg::WIN_BYTES)
            && (byteOff[2:0] == 3'd0);
    slot = byteOff[3 +: SLOT_W];
  end

  // --------------------------------------
  // Field extraction
  // --------------------------------------

  always_comb begin
    // Layout is flow-major, one block per flow
    dec.flow = slot[descMgrPkg::IDX_W +: descMgrPkg::FLOW_W];
    dec.idx  = slot[descMgrPkg::IDX_W-1:0];
    dec.desc = winWr.word;

    // Final word of the block closes the fetch
    dec.last = inWin
               && (dec.idx == descMgrPkg::IDX_W'(descMgrPkg::BLOCK_SIZE - 1));

    // Data words go to the queue
    dec.push = inWin && (winWr.word.data.kind == descMgrPkg::KIND_DATA);
    // Link words only steer the next fetch
    dec.link = inWin && (winWr.word.link.kind == descMgrPkg::KIND_LINK);
  end

endmodule
